/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= decode_tb
RTL_TOP   ?= decode_stage
FILELIST  ?= decode.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* decode.f */
+incdir+logic
logic/decode_pkg.sv
logic/instr_classifier.sv
logic/imm_gen.sv
logic/atomic_cracker.sv
logic/gpr_file.sv
logic/decode_stage.sv
tests/decode_props.sv
tests/decode_tb.sv

/* logic/atomic_cracker.sv */
`include "decode_params.svh"

module atomic_cracker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    stall,
  input  logic                    flush,
  input  logic                    bubble,
  input  decode_pkg::instr_info_t info,
  output decode_pkg::atomic_step_t step,
  output logic                    active,
  output logic                    decode_stall
);

  decode_pkg::crack_state_e state;
  logic start;

  // a live atomic word seen while idle emits step 0 right away
  assign start = (state == decode_pkg::CRACK_IDLE) && !bubble && !flush &&
                 (info.is_fetch_add || info.is_swap);
  assign active = start || (state != decode_pkg::CRACK_IDLE);

  // frontend holds its word until the last micro-op goes out
  assign decode_stall = start || (state == decode_pkg::CRACK_FA_ADD);

  always_comb begin
    case (state)
      decode_pkg::CRACK_FA_ADD: step = 2'd1;
      decode_pkg::CRACK_FA_STORE: step = 2'd2;
      decode_pkg::CRACK_SWAP_STORE: step = 2'd1;
      default: step = 2'd0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= decode_pkg::CRACK_IDLE;
    end else if (!stall) begin
      if (flush) begin
        state <= decode_pkg::CRACK_IDLE;
      end else begin
        case (state)
          decode_pkg::CRACK_IDLE: begin
            if (start) begin
              state <= info.is_fetch_add ? decode_pkg::CRACK_FA_ADD :
                                           decode_pkg::CRACK_SWAP_STORE;
            end
          end
          decode_pkg::CRACK_FA_ADD: state <= decode_pkg::CRACK_FA_STORE;
          default: state <= decode_pkg::CRACK_IDLE;
        endcase
      end
    end
  end

endmodule

/* logic/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// widths
`define DEC_XLEN      32
`define DEC_NUM_GPRS  32

// major opcodes, bits [31:27] of the instruction word
`define OP_ALU_REG    5'd0
`define OP_ALU_IMM    5'd1
`define OP_LUI        5'd2
`define OP_MEM0_ABS   5'd3
`define OP_MEM0_REL   5'd4
`define OP_MEM0_IMM   5'd5
`define OP_MEM1_ABS   5'd6
`define OP_MEM1_REL   5'd7
`define OP_MEM1_IMM   5'd8
`define OP_MEM2_ABS   5'd9
`define OP_MEM2_REL   5'd10
`define OP_MEM2_IMM   5'd11
`define OP_BR         5'd12
`define OP_BRR        5'd13
`define OP_BRR_REL    5'd14
`define OP_SYSCALL    5'd15
`define OP_FA_ABS     5'd16
`define OP_FA_REL     5'd17
`define OP_FA_IMM     5'd18
`define OP_SWAP_ABS   5'd19
`define OP_SWAP_REL   5'd20
`define OP_SWAP_IMM   5'd21
`define OP_ADPC       5'd22
`define OP_INV_LO     5'd23
`define OP_INV_HI     5'd30
`define OP_PRIV       5'd31

// exception codes raised by decode
`define EXC_INVALID   8'h80
`define EXC_PRIV      8'h81

`define ALU_OP_ADD    5'd14

`endif

/* logic/decode_pkg.sv */
`include "decode_params.svh"

package decode_pkg;

  typedef logic [`DEC_XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [4:0] opcode_t;
  typedef logic [4:0] alu_op_t;
  // zero means no exception
  typedef logic [7:0] exc_code_t;
  typedef logic [1:0] atomic_step_t;

  typedef enum logic [1:0] {
    CRACK_IDLE,
    CRACK_FA_ADD,
    CRACK_FA_STORE,
    CRACK_SWAP_STORE
  } crack_state_e;

  // one slot from fetch, live when bubble is low
  typedef struct packed {
    word_t     instr;
    word_t     pc;
    logic      bubble;
    exc_code_t exc;
  } fetch_slot_t;

  typedef struct packed {
    logic     we;
    reg_idx_t target;
    word_t    data;
  } wb_write_t;

  typedef struct packed {
    opcode_t      opcode;
    alu_op_t      alu_op;
    logic [4:0]   branch_code;
    reg_idx_t     s_1;
    reg_idx_t     s_2;
    reg_idx_t     tgt_1;
    reg_idx_t     tgt_2;
    word_t        imm;
    logic         is_load;
    logic         is_store;
    logic         is_branch;
    logic         is_post_inc;
    logic         is_atomic;
    logic         is_fetch_add;
    atomic_step_t atomic_step;
    logic         bubble;
    exc_code_t    exc;
    word_t        pc;
  } uop_t;

  typedef struct packed {
    opcode_t    opcode;
    alu_op_t    alu_op;
    logic [4:0] branch_code;
    reg_idx_t   s_1;
    reg_idx_t   s_2;
    reg_idx_t   tgt_1;
    reg_idx_t   tgt_2;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_post_inc;
    logic       is_fetch_add;
    logic       is_swap;
    // operands of the atomic micro-ops
    reg_idx_t   base_reg;
    reg_idx_t   data_reg;
    exc_code_t  exc;
  } instr_info_t;

endpackage

/* logic/decode_stage.sv */
`include "decode_params.svh"

module decode_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  decode_pkg::fetch_slot_t slot,
  input  logic                    stall,
  input  logic                    flush,
  input  logic                    kmode,
  input  decode_pkg::wb_write_t   wb,
  output decode_pkg::uop_t        uop,
  output decode_pkg::word_t       d_1,
  output decode_pkg::word_t       d_2,
  output logic                    decode_stall
);

  decode_pkg::instr_info_t info;
  decode_pkg::word_t imm;
  decode_pkg::atomic_step_t step;
  logic active;
  logic add_step;
  logic store_step;
  logic kill;
  logic has_exc;
  decode_pkg::uop_t live;
  decode_pkg::uop_t next_uop;

  instr_classifier u_classifier (.instr(slot.instr), .kmode(kmode), .info(info));

  imm_gen u_imm (.instr(slot.instr), .imm(imm));

  atomic_cracker u_cracker (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .flush(flush),
    .bubble(slot.bubble),
    .info(info),
    .step(step),
    .active(active),
    .decode_stall(decode_stall)
  );

  // operands follow the sources of the uop being loaded
  gpr_file u_gpr (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .s_1(next_uop.s_1),
    .s_2(next_uop.s_2),
    .wb(wb),
    .d_1(d_1),
    .d_2(d_2)
  );

  assign add_step = active && info.is_fetch_add && (step == 2'd1);
  assign store_step = active && (info.is_fetch_add ? (step == 2'd2) : (step == 2'd1));

  always_comb begin
    live = '0;
    live.opcode = info.opcode;
    live.alu_op = info.alu_op;
    live.branch_code = info.branch_code;
    live.s_1 = info.s_1;
    live.s_2 = info.s_2;
    live.tgt_1 = info.tgt_1;
    live.tgt_2 = info.tgt_2;
    live.imm = imm;
    live.is_load = info.is_load;
    live.is_store = info.is_store;
    live.is_branch = info.is_branch;
    live.is_post_inc = info.is_post_inc;
    live.pc = slot.pc;
    if (active) begin
      live.is_atomic = 1'b1;
      live.is_fetch_add = info.is_fetch_add;
      live.atomic_step = step;
      case (info.opcode)
        `OP_FA_ABS, `OP_SWAP_ABS: live.opcode = `OP_MEM0_ABS;
        `OP_FA_REL, `OP_SWAP_REL: live.opcode = `OP_MEM0_REL;
        default: live.opcode = `OP_MEM0_IMM;
      endcase
      // tgt_1 of an atomic word is its register a
      if (add_step) begin
        live.opcode = `OP_ALU_REG;
        live.alu_op = `ALU_OP_ADD;
        live.s_1 = info.data_reg;
        live.s_2 = info.tgt_1;
        live.imm = '0;
      end else if (store_step) begin
        live.is_store = 1'b1;
        live.tgt_1 = '0;
        live.s_1 = info.base_reg;
        live.s_2 = info.is_fetch_add ? info.tgt_1 : info.data_reg;
      end else begin
        live.is_load = 1'b1;
        live.s_1 = info.base_reg;
        live.s_2 = info.data_reg;
      end
    end
  end

  assign kill = flush || slot.bubble;
  assign has_exc = (slot.exc != '0) || (info.exc != '0);

  always_comb begin
    next_uop = live;
    if (kill) begin
      next_uop = '0;
      next_uop.bubble = 1'b1;
    end else if (has_exc) begin
      // faulting slot stays live so writeback can trap on it
      next_uop = '0;
      next_uop.pc = slot.pc;
      next_uop.exc = (slot.exc != '0) ? slot.exc : info.exc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      uop <= '0;
      uop.bubble <= 1'b1;
    end else if (!stall) begin
      uop <= next_uop;
    end
  end

endmodule

/* logic/gpr_file.sv */
`include "decode_params.svh"

module gpr_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall,
  input  decode_pkg::reg_idx_t  s_1,
  input  decode_pkg::reg_idx_t  s_2,
  input  decode_pkg::wb_write_t wb,
  output decode_pkg::word_t     d_1,
  output decode_pkg::word_t     d_2
);

  decode_pkg::word_t regs [`DEC_NUM_GPRS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `DEC_NUM_GPRS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.target != '0) begin
      regs[wb.target] <= wb.data;
    end
  end

  // read ports sample the array before this edge's write lands
  always_ff @(posedge clk) begin
    if (rst) begin
      d_1 <= '0;
      d_2 <= '0;
    end else if (!stall) begin
      d_1 <= (s_1 == '0) ? '0 : regs[s_1];
      d_2 <= (s_2 == '0) ? '0 : regs[s_2];
    end
  end

endmodule

/* logic/imm_gen.sv */
`include "decode_params.svh"

module imm_gen (
  input  decode_pkg::word_t instr,
  output decode_pkg::word_t imm
);

  decode_pkg::opcode_t op;
  decode_pkg::alu_op_t alu_op;
  logic [4:0] byte_shift;

  assign op = instr[31:27];
  assign alu_op = instr[16:12];
  // bitwise immediates land on a byte lane
  assign byte_shift = {instr[9:8], 3'b000};

  always_comb begin
    imm = '0;
    case (op)
      `OP_ALU_IMM: begin
        if (alu_op <= 5'd6) begin
          imm = {24'b0, instr[7:0]} << byte_shift;
        end else if (alu_op <= 5'd13) begin
          imm = {27'b0, instr[4:0]};
        end else if (alu_op <= 5'd18) begin
          imm = {{20{instr[11]}}, instr[11:0]};
        end
      end
      `OP_LUI: imm = {instr[21:0], 10'b0};
      `OP_BR, `OP_ADPC: imm = {{10{instr[21]}}, instr[21:0]};
      `OP_MEM0_ABS, `OP_MEM1_ABS, `OP_MEM2_ABS: begin
        // scaled offset
        imm = {{20{instr[11]}}, instr[11:0]} << instr[13:12];
      end
      `OP_MEM0_REL, `OP_MEM1_REL, `OP_MEM2_REL: begin
        imm = {{16{instr[15]}}, instr[15:0]};
      end
      `OP_MEM0_IMM, `OP_MEM1_IMM, `OP_MEM2_IMM: begin
        imm = {{11{instr[20]}}, instr[20:0]};
      end
      `OP_FA_IMM, `OP_SWAP_IMM: imm = {{15{instr[16]}}, instr[16:0]};
      `OP_FA_ABS, `OP_FA_REL, `OP_SWAP_ABS, `OP_SWAP_REL: begin
        imm = {{20{instr[11]}}, instr[11:0]};
      end
      default: imm = '0;
    endcase
  end

endmodule

/* logic/instr_classifier.sv */
`include "decode_params.svh"

module instr_classifier (
  input  decode_pkg::word_t       instr,
  input  logic                    kmode,
  output decode_pkg::instr_info_t info
);

  logic known;
  logic bad_opcode;
  logic is_alu;
  logic is_mem;
  logic is_branch;
  logic is_syscall;
  logic is_priv;
  decode_pkg::word_t iw;
  decode_pkg::opcode_t op;
  decode_pkg::alu_op_t alu_op;
  decode_pkg::reg_idx_t r_a;
  decode_pkg::reg_idx_t r_b;
  logic [4:0] priv_type;
  logic [1:0] inc_type;
  logic load_bit;
  logic is_load;
  logic is_store;
  logic is_abs_mem;
  logic alias_post_inc;
  logic invalid;

  // an x opcode matches no item and leaves known low
  always_comb begin
    known = 1'b1;
    bad_opcode = 1'b0;
    is_alu = 1'b0;
    is_mem = 1'b0;
    is_branch = 1'b0;
    is_syscall = 1'b0;
    is_priv = 1'b0;
    case (instr[31:27]) inside
      `OP_ALU_REG, `OP_ALU_IMM: is_alu = 1'b1;
      `OP_LUI, `OP_ADPC: ;
      [`OP_MEM0_ABS:`OP_MEM2_IMM]: is_mem = 1'b1;
      `OP_BR, `OP_BRR, `OP_BRR_REL: is_branch = 1'b1;
      `OP_SYSCALL: is_syscall = 1'b1;
      [`OP_FA_ABS:`OP_SWAP_IMM]: ;
      [`OP_INV_LO:`OP_INV_HI]: bad_opcode = 1'b1;
      `OP_PRIV: is_priv = 1'b1;
      default: known = 1'b0;
    endcase
  end

  // unknown words decode as nop
  assign iw = known ? instr : '0;
  assign op = iw[31:27];

  // register branches keep their operands in the low bits
  assign r_a = (op == `OP_BRR || op == `OP_BRR_REL) ? iw[9:5] : iw[26:22];
  assign r_b = (op == `OP_BRR || op == `OP_BRR_REL) ? iw[4:0] : iw[21:17];
  assign alu_op = (op == `OP_ALU_REG) ? iw[9:5] : iw[16:12];
  assign priv_type = iw[16:12];
  // 0 offset, 1 pre-increment, 2 post-increment
  assign inc_type = iw[15:14];

  assign load_bit = (op == `OP_MEM0_IMM || op == `OP_MEM1_IMM || op == `OP_MEM2_IMM) ?
                    iw[21] : iw[16];
  assign is_load = is_mem && load_bit;
  assign is_store = is_mem && !load_bit;
  assign is_abs_mem = (op == `OP_MEM0_ABS || op == `OP_MEM1_ABS || op == `OP_MEM2_ABS);
  assign alias_post_inc = is_abs_mem && (inc_type == 2'd2) && is_load && (r_a == r_b);

  assign invalid = bad_opcode ||
                   (is_alu && op == `OP_ALU_IMM && alu_op > 5'd18) ||
                   (is_alu && op == `OP_ALU_REG && alu_op > 5'd22) ||
                   (is_branch && iw[26:22] > 5'd18) ||
                   (is_syscall && iw[7:0] != 8'd1) ||
                   (is_priv && priv_type > 5'd3);

  always_comb begin
    info = '0;
    info.opcode = op;
    info.alu_op = alu_op;
    info.branch_code = iw[26:22];
    // lui, immediate forms, syscall and alu mov do not read r_b
    if (op == `OP_LUI || op == `OP_MEM0_IMM || op == `OP_MEM1_IMM || op == `OP_MEM2_IMM ||
        op == `OP_BR || op == `OP_SYSCALL || (is_alu && alu_op == 5'd6)) begin
      info.s_1 = '0;
    end else begin
      info.s_1 = r_b;
    end
    if (is_store || is_priv) begin
      info.s_2 = r_a;
    end else if (op == `OP_ALU_REG) begin
      info.s_2 = iw[4:0];
    end
    info.tgt_1 = (is_store || alias_post_inc) ? '0 : r_a;
    info.tgt_2 = (is_abs_mem && inc_type != 2'd0) ? r_b : '0;
    info.is_load = is_load;
    info.is_store = is_store;
    info.is_branch = is_branch;
    info.is_post_inc = is_abs_mem && (inc_type == 2'd2);
    info.is_fetch_add = (op == `OP_FA_ABS || op == `OP_FA_REL || op == `OP_FA_IMM);
    info.is_swap = (op == `OP_SWAP_ABS || op == `OP_SWAP_REL || op == `OP_SWAP_IMM);
    info.base_reg = (op == `OP_FA_IMM || op == `OP_SWAP_IMM) ? '0 : iw[16:12];
    info.data_reg = iw[21:17];
    if (invalid) begin
      info.exc = `EXC_INVALID;
    end else if (is_priv && !kmode) begin
      info.exc = `EXC_PRIV;
    end else if (is_syscall) begin
      info.exc = iw[7:0];
    end
  end

endmodule

/* tests/decode_props.sv */
module decode_props (
  input logic             clk,
  input logic             rst,
  input logic             stall,
  input logic             flush,
  input logic             decode_stall,
  input decode_pkg::uop_t uop
);

  timeunit 1ns;
  timeprecision 1ps;

  // non-stalled cycles in a row with decode_stall high, saturating
  logic [1:0] ds_run;

  always_ff @(posedge clk) begin
    if (rst) begin
      ds_run <= 2'd0;
    end else if (!stall) begin
      ds_run <= decode_stall ? ds_run + {1'b0, ds_run != 2'd3} : 2'd0;
    end
  end

  hold_under_stall: assert property (@(posedge clk) disable iff (rst)
    stall |=> $stable(uop))
    else $error("uop changed while stall was high");

  crack_length: assert property (@(posedge clk) disable iff (rst)
    !(decode_stall && !stall && ds_run >= 2'd2))
    else $error("decode_stall high for more than two micro-ops in a row");

  flush_gives_bubble: assert property (@(posedge clk) disable iff (rst)
    (flush && !stall) |=> uop.bubble)
    else $error("flushed slot did not give a bubble");

  reset_gives_bubble: assert property (@(posedge clk)
    rst |=> uop.bubble)
    else $error("uop is not a bubble after reset");

endmodule

bind decode_stage decode_props u_props (
  .clk(clk),
  .rst(rst),
  .stall(stall),
  .flush(flush),
  .decode_stall(decode_stall),
  .uop(uop)
);

/* tests/decode_tb.sv */
`include "decode_params.svh"

module decode_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RAND = 80;
  localparam int N_EXC = 40;
  localparam int N_FA = 12;
  localparam int N_SWAP = 12;
  localparam int N_WB = 16;
  localparam int N_BUB = 20;
  // worst case cycles per test, stalls included
  localparam int TEST_CYCLES = 8 + N_RAND + N_EXC + N_FA * 10 + N_SWAP * 4 + N_WB * 3 +
                               N_BUB * 2 + 20;

  logic clk;
  logic rst;
  decode_pkg::fetch_slot_t slot;
  logic stall;
  logic flush;
  logic kmode;
  decode_pkg::wb_write_t wb;
  decode_pkg::uop_t uop;
  decode_pkg::word_t d_1;
  decode_pkg::word_t d_2;
  logic decode_stall;

  int seed = 32'hf35b_dac9;
  int errors = 0;
  int checks = 0;
  decode_pkg::word_t model [32];
  decode_pkg::word_t cur_pc;
  decode_pkg::uop_t exp_uop;
  decode_pkg::word_t exp_d1;
  decode_pkg::word_t exp_d2;
  logic exp_ds;
  logic pending;

  decode_stage dut (
    .clk(clk),
    .rst(rst),
    .slot(slot),
    .stall(stall),
    .flush(flush),
    .kmode(kmode),
    .wb(wb),
    .uop(uop),
    .d_1(d_1),
    .d_2(d_2),
    .decode_stall(decode_stall)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic decode_pkg::word_t immediate_of(input decode_pkg::word_t instr);
    logic [4:0] op;
    logic [4:0] aop;
    decode_pkg::word_t sx12;
    op = instr[31:27];
    aop = instr[16:12];
    sx12 = {{20{instr[11]}}, instr[11:0]};
    if (op == `OP_ALU_IMM && aop <= 5'd6) begin
      return {24'b0, instr[7:0]} << (5'd8 * instr[9:8]);
    end else if (op == `OP_ALU_IMM && aop <= 5'd13) begin
      return {27'b0, instr[4:0]};
    end else if (op == `OP_ALU_IMM && aop <= 5'd18) begin
      return sx12;
    end else if (op == `OP_LUI) begin
      return {instr[21:0], 10'b0};
    end else if (op == `OP_BR || op == `OP_ADPC) begin
      return {{10{instr[21]}}, instr[21:0]};
    end else if (op == `OP_MEM0_ABS || op == `OP_MEM1_ABS || op == `OP_MEM2_ABS) begin
      return sx12 << instr[13:12];
    end else if (op == `OP_MEM0_REL || op == `OP_MEM1_REL || op == `OP_MEM2_REL) begin
      return {{16{instr[15]}}, instr[15:0]};
    end else if (op == `OP_MEM0_IMM || op == `OP_MEM1_IMM || op == `OP_MEM2_IMM) begin
      return {{11{instr[20]}}, instr[20:0]};
    end else if (op == `OP_FA_IMM || op == `OP_SWAP_IMM) begin
      return {{15{instr[16]}}, instr[16:0]};
    end else if (op >= `OP_FA_ABS && op <= `OP_SWAP_REL) begin
      return sx12;
    end
    return '0;
  endfunction

  function automatic decode_pkg::uop_t expected_uop(
    input decode_pkg::word_t instr, input decode_pkg::word_t pc, input logic km,
    input logic bub, input logic fl, input decode_pkg::exc_code_t sexc,
    input decode_pkg::atomic_step_t step);
    decode_pkg::uop_t u;
    logic [4:0] op;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] aop;
    logic [4:0] base;
    logic imm_form;
    logic abs_form;
    logic ld;
    logic st;
    logic bad;
    logic fa;
    logic sw;
    decode_pkg::exc_code_t e;
    u = '0;
    if (bub || fl) begin
      u.bubble = 1'b1;
      return u;
    end
    op = instr[31:27];
    ra = (op == `OP_BRR || op == `OP_BRR_REL) ? instr[9:5] : instr[26:22];
    rb = (op == `OP_BRR || op == `OP_BRR_REL) ? instr[4:0] : instr[21:17];
    aop = (op == `OP_ALU_REG) ? instr[9:5] : instr[16:12];
    imm_form = (op == `OP_MEM0_IMM || op == `OP_MEM1_IMM || op == `OP_MEM2_IMM);
    abs_form = (op == `OP_MEM0_ABS || op == `OP_MEM1_ABS || op == `OP_MEM2_ABS);
    ld = (op >= `OP_MEM0_ABS && op <= `OP_MEM2_IMM) && (imm_form ? instr[21] : instr[16]);
    st = (op >= `OP_MEM0_ABS && op <= `OP_MEM2_IMM) && !ld;
    bad = (op >= `OP_INV_LO && op <= `OP_INV_HI) ||
          (op == `OP_ALU_IMM && aop > 5'd18) || (op == `OP_ALU_REG && aop > 5'd22) ||
          (op >= `OP_BR && op <= `OP_BRR_REL && instr[26:22] > 5'd18) ||
          (op == `OP_SYSCALL && instr[7:0] != 8'd1) ||
          (op == `OP_PRIV && instr[16:12] > 5'd3);
    e = sexc;
    if (e == '0) begin
      if (bad) begin
        e = `EXC_INVALID;
      end else if (op == `OP_PRIV && !km) begin
        e = `EXC_PRIV;
      end else if (op == `OP_SYSCALL) begin
        e = instr[7:0];
      end
    end
    u.pc = pc;
    if (e != '0) begin
      u.exc = e;
      return u;
    end
    u.opcode = op;
    u.alu_op = aop;
    u.branch_code = instr[26:22];
    u.imm = immediate_of(instr);
    fa = (op >= `OP_FA_ABS && op <= `OP_FA_IMM);
    sw = (op >= `OP_SWAP_ABS && op <= `OP_SWAP_IMM);
    if (fa || sw) begin
      base = (op == `OP_FA_IMM || op == `OP_SWAP_IMM) ? 5'd0 : instr[16:12];
      u.is_atomic = 1'b1;
      u.is_fetch_add = fa;
      u.atomic_step = step;
      u.tgt_1 = instr[26:22];
      u.opcode = (fa ? op - `OP_FA_ABS : op - `OP_SWAP_ABS) + `OP_MEM0_ABS;
      if (fa && step == 2'd1) begin
        u.opcode = `OP_ALU_REG;
        u.alu_op = `ALU_OP_ADD;
        u.s_1 = instr[21:17];
        u.s_2 = instr[26:22];
        u.imm = '0;
      end else if ((fa && step == 2'd2) || (sw && step == 2'd1)) begin
        u.is_store = 1'b1;
        u.tgt_1 = '0;
        u.s_1 = base;
        u.s_2 = fa ? instr[26:22] : instr[21:17];
      end else begin
        u.is_load = 1'b1;
        u.s_1 = base;
        u.s_2 = instr[21:17];
      end
      return u;
    end
    if (op == `OP_LUI || imm_form || op == `OP_BR || op == `OP_SYSCALL ||
        ((op == `OP_ALU_REG || op == `OP_ALU_IMM) && aop == 5'd6)) begin
      u.s_1 = '0;
    end else begin
      u.s_1 = rb;
    end
    u.s_2 = (st || op == `OP_PRIV) ? ra : ((op == `OP_ALU_REG) ? instr[4:0] : 5'd0);
    u.tgt_1 = (st || (abs_form && instr[15:14] == 2'd2 && ld && ra == rb)) ? 5'd0 : ra;
    u.tgt_2 = (abs_form && instr[15:14] != 2'd0) ? rb : 5'd0;
    u.is_load = ld;
    u.is_store = st;
    u.is_branch = (op >= `OP_BR && op <= `OP_BRR_REL);
    u.is_post_inc = abs_form && instr[15:14] == 2'd2;
    return u;
  endfunction

  function automatic decode_pkg::word_t valid_word();
    decode_pkg::word_t w;
    w = rnd();
    case (rnd() % 32'd6)
      0: begin
        w[31:27] = `OP_ALU_REG;
        w[9:5] = 5'(rnd() % 32'd23);
      end
      1: begin
        w[31:27] = `OP_ALU_IMM;
        w[16:12] = 5'(rnd() % 32'd19);
      end
      2: w[31:27] = `OP_LUI;
      3: w[31:27] = 5'(32'd3 + rnd() % 32'd9);
      4: begin
        w[31:27] = 5'(32'd12 + rnd() % 32'd3);
        w[26:22] = 5'(rnd() % 32'd19);
      end
      default: w[31:27] = `OP_ADPC;
    endcase
    return w;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
  endtask

  // every uop field and both operands against the current expectation
  task automatic compare_outputs();
    check_val("uop.opcode", 32'(uop.opcode), 32'(exp_uop.opcode));
    check_val("uop.alu_op", 32'(uop.alu_op), 32'(exp_uop.alu_op));
    check_val("uop.branch_code", 32'(uop.branch_code), 32'(exp_uop.branch_code));
    check_val("uop.s_1", 32'(uop.s_1), 32'(exp_uop.s_1));
    check_val("uop.s_2", 32'(uop.s_2), 32'(exp_uop.s_2));
    check_val("uop.tgt_1", 32'(uop.tgt_1), 32'(exp_uop.tgt_1));
    check_val("uop.tgt_2", 32'(uop.tgt_2), 32'(exp_uop.tgt_2));
    check_val("uop.imm", uop.imm, exp_uop.imm);
    check_val("uop.is_load", 32'(uop.is_load), 32'(exp_uop.is_load));
    check_val("uop.is_store", 32'(uop.is_store), 32'(exp_uop.is_store));
    check_val("uop.is_branch", 32'(uop.is_branch), 32'(exp_uop.is_branch));
    check_val("uop.is_post_inc", 32'(uop.is_post_inc), 32'(exp_uop.is_post_inc));
    check_val("uop.is_atomic", 32'(uop.is_atomic), 32'(exp_uop.is_atomic));
    check_val("uop.is_fetch_add", 32'(uop.is_fetch_add), 32'(exp_uop.is_fetch_add));
    check_val("uop.atomic_step", 32'(uop.atomic_step), 32'(exp_uop.atomic_step));
    check_val("uop.bubble", 32'(uop.bubble), 32'(exp_uop.bubble));
    check_val("uop.exc", 32'(uop.exc), 32'(exp_uop.exc));
    check_val("uop.pc", uop.pc, exp_uop.pc);
    check_val("d_1", d_1, exp_d1);
    check_val("d_2", d_2, exp_d2);
  endtask

  // one slot per falling edge; expected values are set for the next rising edge
  task automatic drive(input decode_pkg::word_t instr, input logic km,
                       input decode_pkg::exc_code_t sexc, input logic bub, input logic fl,
                       input logic st, input decode_pkg::atomic_step_t step, input logic ds,
                       input decode_pkg::wb_write_t w);
    decode_pkg::uop_t e;
    @(negedge clk);
    slot.instr = instr;
    slot.pc = cur_pc;
    slot.bubble = bub;
    slot.exc = sexc;
    kmode = km;
    flush = fl;
    stall = st;
    wb = w;
    if (!st) begin
      e = expected_uop(instr, cur_pc, km, bub, fl, sexc, step);
      exp_uop = e;
      exp_d1 = model[e.s_1];
      exp_d2 = model[e.s_2];
      if (!ds) begin
        cur_pc = cur_pc + 32'd4;
      end
    end
    exp_ds = ds;
    pending = 1'b1;
    if (w.we && w.target != 5'd0) begin
      model[w.target] = w.data;
    end
  endtask

  task automatic idle();
    drive('0, 1'b1, '0, 1'b1, 1'b0, 1'b0, 2'd0, 1'b0, '0);
  endtask

  task automatic report(input string name, input int errs_before);
    idle();
    $display("%s: %0d errors", name, errors - errs_before);
  endtask

  // compares each edge against the values set by the last drive
  always begin
    logic ds_s;
    logic p;
    @(posedge clk);
    ds_s = decode_stall;
    p = pending;
    #10;
    if (p && !rst) begin
      check_val("decode_stall", 32'(ds_s), 32'(exp_ds));
      compare_outputs();
    end
  end

  initial begin
    #((TEST_CYCLES + 100) * 100);
    $display("watchdog expired after %0d cycles without finishing", TEST_CYCLES + 100);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    decode_pkg::word_t w;
    decode_pkg::wb_write_t wr;
    logic [4:0] r1;
    logic [4:0] r2;
    int e0;
    int n;
    clk = 1'b0;
    rst = 1'b1;
    slot = '0;
    slot.bubble = 1'b1;
    stall = 1'b0;
    flush = 1'b0;
    kmode = 1'b1;
    wb = '0;
    cur_pc = 32'h0000_1000;
    pending = 1'b0;
    exp_ds = 1'b0;
    exp_d1 = '0;
    exp_d2 = '0;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;
    e0 = errors;
    // reset leaves a bubble with every other field cleared
    exp_uop = '0;
    exp_uop.bubble = 1'b1;
    compare_outputs();
    check_val("decode_stall after reset", 32'(decode_stall), 32'd0);
    $display("reset: %0d errors", errors - e0);

    e0 = errors;
    for (int i = 0; i < N_RAND; i++) begin
      drive(valid_word(), 1'b1, '0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, '0);
    end
    report("random valid words", e0);

    e0 = errors;
    for (int i = 0; i < N_EXC; i++) begin
      w = rnd();
      case (rnd() % 32'd6)
        0: w[31:27] = 5'(32'd23 + rnd() % 32'd8);
        1: begin
          w[31:27] = `OP_ALU_IMM;
          w[16:12] = 5'(32'd19 + rnd() % 32'd13);
        end
        2: begin
          w[31:27] = `OP_ALU_REG;
          w[9:5] = 5'(32'd23 + rnd() % 32'd9);
        end
        3: begin
          w[31:27] = `OP_SYSCALL;
          w[7:0] = 8'(32'd2 + rnd() % 32'd254);
        end
        4: begin
          w[31:27] = `OP_SYSCALL;
          w[7:0] = 8'd1;
        end
        default: begin
          w[31:27] = `OP_PRIV;
          w[16:12] = 5'(rnd() % 32'd4);
        end
      endcase
      drive(w, rnd() % 32'd2 == 32'd0, '0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, '0);
    end
    report("exceptions", e0);

    e0 = errors;
    for (int i = 0; i < N_FA; i++) begin
      w = rnd();
      w[31:27] = 5'(32'd16 + rnd() % 32'd3);
      for (int s = 0; s < 3; s++) begin
        n = int'(rnd() % 32'd3);
        repeat (n) drive(w, 1'b1, '0, 1'b0, 1'b0, 1'b1, 2'(s), s < 2, '0);
        drive(w, 1'b1, '0, 1'b0, 1'b0, 1'b0, 2'(s), s < 2, '0);
      end
    end
    report("fetch-add cracking", e0);

    e0 = errors;
    for (int i = 0; i < N_SWAP; i++) begin
      w = rnd();
      w[31:27] = 5'(32'd19 + rnd() % 32'd3);
      drive(w, 1'b1, '0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b1, '0);
      if (i % 2 == 0) begin
        drive(w, 1'b1, '0, 1'b0, 1'b0, 1'b0, 2'd1, 1'b0, '0);
      end else begin
        // flush in the middle of the crack, then a plain word
        drive(w, 1'b1, '0, 1'b0, 1'b1, 1'b0, 2'd1, 1'b0, '0);
        drive(valid_word(), 1'b1, '0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, '0);
      end
    end
    report("swap cracking and flush", e0);

    e0 = errors;
    for (int i = 0; i < N_WB; i++) begin
      r1 = 5'(32'd1 + rnd() % 32'd31);
      r2 = (i % 4 == 0) ? 5'd0 : 5'(rnd());
      wr.we = 1'b1;
      wr.target = r1;
      wr.data = rnd();
      drive('0, 1'b1, '0, 1'b1, 1'b0, 1'b0, 2'd0, 1'b0, wr);
      wr.target = r2;
      wr.data = rnd();
      drive('0, 1'b1, '0, 1'b1, 1'b0, 1'b0, 2'd0, 1'b0, wr);
      w = '0;
      w[31:27] = `OP_ALU_REG;
      w[26:22] = 5'(rnd());
      w[21:17] = r1;
      w[4:0] = r2;
      drive(w, 1'b1, '0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, '0);
    end
    report("register file", e0);

    e0 = errors;
    for (int i = 0; i < N_BUB; i++) begin
      drive(rnd(), 1'b1, '0, 1'b1, 1'b0, 1'b0, 2'd0, 1'b0, '0);
      drive(valid_word(), 1'b1, 8'(32'd1 + rnd() % 32'd127), 1'b0, 1'b0, 1'b0, 2'd0,
            1'b0, '0);
    end
    report("bubbles and slot exceptions", e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
